/* source/mdu_pkg.sv */
package mdu_pkg;

	// One general purpose register value.
	typedef logic [31:0] word_t;

	// HI:LO pair, also the full multiplier product.
	typedef logic [63:0] dword_t;

	// Operation codes issued by the pipeline.
	typedef enum logic [4:0] {
		op_none  = 5'd0,
		op_mult  = 5'd1,
		op_multu = 5'd2,
		op_div   = 5'd3,
		op_divu  = 5'd4,
		op_mfhi  = 5'd5,
		op_mflo  = 5'd6,
		op_mthi  = 5'd7,
		op_mtlo  = 5'd8,
		op_madd  = 5'd9,  // HI:LO + rs * rt, signed.
		op_maddu = 5'd10,
		op_msub  = 5'd11, // HI:LO - rs * rt, signed.
		op_msubu = 5'd12
	} mdu_op_t;

endpackage

/* source/mdu_multiplier.sv */
`timescale 1ns/1ps

module mdu_multiplier import mdu_pkg::*; #(
	parameter int MULT_STEP = 2
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic is_signed,
	input word_t a,
	input word_t b,
	output dword_t product,
	output logic done
);

	localparam int STEPS = 32 / MULT_STEP;

	logic [5:0] count; // Steps still to run.
	dword_t mcand;     // Multiplicand magnitude, moves left each step.
	word_t mplier;     // Multiplier magnitude, moves right each step.
	dword_t acc;
	logic negate;
	dword_t acc_next;
	word_t a_mag;
	word_t b_mag;

	// Work on magnitudes, the sign is put back at the end.
	assign a_mag = (is_signed && a[31]) ? -a : a;
	assign b_mag = (is_signed && b[31]) ? -b : b;

	// MULT_STEP partial products per cycle.
	always_comb begin
		acc_next = acc;
		for (int i = 0; i < MULT_STEP; i++) begin
			if (mplier[i]) begin
				acc_next = acc_next + (mcand << i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				count <= 6'(STEPS);
			end else if (count != 0) begin
				count <= count - 1'b1;
				if (count == 1) begin
					done <= 1'b1; // Product lands with it.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= {32'b0, a_mag};
			mplier <= b_mag;
			acc <= '0;
			negate <= is_signed && (a[31] ^ b[31]);
		end else if (count != 0) begin
			mcand <= mcand << MULT_STEP;
			mplier <= mplier >> MULT_STEP;
			acc <= acc_next;
			if (count == 1) begin
				product <= negate ? -acc_next : acc_next;
			end
		end
	end

	// Control must wait for done before the next start.
	assert property (@(posedge clk) disable iff (reset) start |-> count == 0)
		else $error("multiplier started while running");

endmodule

/* source/mdu_divider.sv */
`timescale 1ns/1ps

module mdu_divider import mdu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic is_signed,
	input word_t dividend,
	input word_t divisor,
	output word_t quotient,
	output word_t remainder,
	output logic div_by_zero,
	output logic done
);

	logic [5:0] count; // Quotient bits still to produce.
	word_t rem;
	word_t quo;        // Dividend shifts out, quotient shifts in.
	word_t dsr;        // Divisor magnitude.
	logic neg_quo;
	logic neg_rem;
	logic [32:0] rem_shift;
	logic [32:0] diff;
	word_t rem_next;
	word_t quo_next;
	word_t dvd_mag;
	word_t dsr_mag;

	assign dvd_mag = (is_signed && dividend[31]) ? -dividend : dividend;
	assign dsr_mag = (is_signed && divisor[31]) ? -divisor : divisor;

	// One restoring step. Bit 32 of diff is the borrow.
	always_comb begin
		rem_shift = {rem, quo[31]};
		diff = rem_shift - {1'b0, dsr};
		if (diff[32]) begin
			rem_next = rem_shift[31:0]; // Restore.
			quo_next = {quo[30:0], 1'b0};
		end else begin
			rem_next = diff[31:0];
			quo_next = {quo[30:0], 1'b1};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			done <= 1'b0;
			div_by_zero <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				count <= 6'd32;
				div_by_zero <= (divisor == '0);
			end else if (count != 0) begin
				count <= count - 1'b1;
				if (count == 1) begin
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem <= '0;
			quo <= dvd_mag;
			dsr <= dsr_mag;
			neg_quo <= is_signed && (dividend[31] ^ divisor[31]);
			neg_rem <= is_signed && dividend[31]; // Remainder follows the dividend.
		end else if (count != 0) begin
			rem <= rem_next;
			quo <= quo_next;
			if (count == 1) begin
				// Truncates toward zero. 0x80000000 / -1 wraps back to itself.
				quotient <= neg_quo ? -quo_next : quo_next;
				remainder <= neg_rem ? -rem_next : rem_next;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) start |-> count == 0)
		else $error("divider started while busy");

endmodule

/* source/mdu_control.sv */
`timescale 1ns/1ps

module mdu_control import mdu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic en,
	input mdu_op_t op,
	input word_t rs,
	input word_t rt,
	output word_t result,
	output logic busy,
	output logic mul_start,
	output logic div_start,
	output logic is_signed,
	output word_t op_a,
	output word_t op_b,
	input dword_t product,
	input logic mul_done,
	input word_t quotient,
	input word_t remainder,
	input logic div_done,
	input logic div_by_zero
);

	typedef enum logic [1:0] {
		st_idle,
		st_launch,
		st_mul_wait,
		st_div_wait
	} state_t;

	state_t state;
	mdu_op_t cur_op;  // Operation being worked on.
	word_t hi;
	word_t lo;
	logic is_mul_op;
	logic is_div_op;
	logic long_op;
	logic cur_is_div;
	dword_t hilo_next;

	assign is_mul_op = op inside {op_mult, op_multu, op_madd, op_maddu, op_msub, op_msubu};
	assign is_div_op = op inside {op_div, op_divu};
	assign long_op = en && (is_mul_op || is_div_op);

	assign cur_is_div = cur_op inside {op_div, op_divu};
	assign is_signed = cur_op inside {op_mult, op_div, op_madd, op_msub};

	// High in the presenting cycle too, so the pipeline stalls at once.
	assign busy = (state != st_idle) || long_op;

	assign result = busy ? '0 :
		(op == op_mfhi) ? hi :
		(op == op_mflo) ? lo : '0;

	assign mul_start = (state == st_launch) && !cur_is_div;
	assign div_start = (state == st_launch) && cur_is_div;

	// New HI:LO from the product.
	always_comb begin
		case (cur_op)
			op_madd, op_maddu: hilo_next = {hi, lo} + product;
			op_msub, op_msubu: hilo_next = {hi, lo} - product;
			default: hilo_next = product;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			cur_op <= op_none;
			hi <= '0;
			lo <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (long_op) begin
						state <= st_launch;
						cur_op <= op;
					end else if (en && op == op_mthi) begin
						hi <= rs;
					end else if (en && op == op_mtlo) begin
						lo <= rs;
					end
				end
				st_launch: begin
					state <= cur_is_div ? st_div_wait : st_mul_wait;
				end
				st_mul_wait: begin
					if (mul_done) begin
						{hi, lo} <= hilo_next;
						state <= st_idle;
					end
				end
				st_div_wait: begin
					if (div_done) begin
						if (!div_by_zero) begin // HI and LO kept on zero divisor.
							hi <= remainder;
							lo <= quotient;
						end
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Operands held for the arithmetic units.
	always_ff @(posedge clk) begin
		if (state == st_idle && long_op) begin
			op_a <= rs;
			op_b <= rt;
		end
	end

	assert property (@(posedge clk) disable iff (reset) mul_done |-> state == st_mul_wait)
		else $error("multiplier done while not waiting");

	assert property (@(posedge clk) disable iff (reset) div_done |-> state == st_div_wait)
		else $error("divider done while not waiting");

endmodule

/* source/mdu.sv */
`timescale 1ns/1ps

module mdu import mdu_pkg::*; #(
	parameter int MULT_STEP = 2 // Product bits per cycle: 1, 2 or 4.
) (
	input logic clk,
	input logic reset,
	input word_t rs,
	input word_t rt,
	input mdu_op_t op,
	input logic en,
	output word_t result,
	output logic busy
);

	logic mul_start;
	logic div_start;
	logic is_signed;
	word_t op_a;
	word_t op_b;
	dword_t product;
	logic mul_done;
	word_t quotient;
	word_t remainder;
	logic div_done;
	logic div_by_zero;

	mdu_control u_control (
		.clk(clk),
		.reset(reset),
		.en(en),
		.op(op),
		.rs(rs),
		.rt(rt),
		.result(result),
		.busy(busy),
		.mul_start(mul_start),
		.div_start(div_start),
		.is_signed(is_signed),
		.op_a(op_a),
		.op_b(op_b),
		.product(product),
		.mul_done(mul_done),
		.quotient(quotient),
		.remainder(remainder),
		.div_done(div_done),
		.div_by_zero(div_by_zero)
	);

	mdu_multiplier #(
		.MULT_STEP(MULT_STEP)
	) u_multiplier (
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.is_signed(is_signed),
		.a(op_a),
		.b(op_b),
		.product(product),
		.done(mul_done)
	);

	mdu_divider u_divider (
		.clk(clk),
		.reset(reset),
		.start(div_start),
		.is_signed(is_signed),
		.dividend(op_a),
		.divisor(op_b),
		.quotient(quotient),
		.remainder(remainder),
		.div_by_zero(div_by_zero),
		.done(div_done)
	);

endmodule

/* tests/mdu_tb.sv */
`timescale 1ns/1ps

module mdu_tb import mdu_pkg::*; ();

	logic clk;
	logic reset;
	word_t rs;
	word_t rt;
	mdu_op_t op;
	logic en;
	word_t result;
	logic busy;

	word_t model_hi;   // Expected HI.
	word_t model_lo;   // Expected LO.
	logic compare_en;  // Unit known idle, result is checked every cycle.
	integer seed;

	mdu UUT (
		.clk(clk),
		.reset(reset),
		.rs(rs),
		.rt(rt),
		.op(op),
		.en(en),
		.result(result),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Expected HI:LO after one accepted operation.
	function automatic dword_t mdu_model(mdu_op_t kind, word_t a, word_t b, dword_t hilo);
		dword_t prod_s;
		dword_t prod_u;
		word_t q;
		word_t r;
		dword_t new_hilo;
		prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // Low 64 bits of the signed product.
		prod_u = {32'b0, a} * {32'b0, b};
		new_hilo = hilo;
		case (kind)
			op_mult: new_hilo = prod_s;
			op_multu: new_hilo = prod_u;
			op_madd: new_hilo = hilo + prod_s;
			op_maddu: new_hilo = hilo + prod_u;
			op_msub: new_hilo = hilo - prod_s;
			op_msubu: new_hilo = hilo - prod_u;
			op_mthi: new_hilo = {a, hilo[31:0]};
			op_mtlo: new_hilo = {hilo[63:32], a};
			op_div: begin
				if (b != 0) begin
					if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
						q = a;
						r = '0;
					end else begin
						q = $signed(a) / $signed(b);
						r = $signed(a) % $signed(b);
					end
					new_hilo = {r, q};
				end
			end
			op_divu: begin
				if (b != 0) begin
					q = a / b;
					r = a % b;
					new_hilo = {r, q};
				end
			end
			default: new_hilo = hilo;
		endcase
		return new_hilo;
	endfunction

	task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, expected);
			$display("test failed");
			$fatal(1, "Value check failed.");
		end
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (busy) begin
			$display("Timeout: busy never dropped within 100 cycles.");
			$display("test failed");
			$fatal(1, "Unit stuck busy.");
		end
	endtask

	// Present one op while idle, follow it in the model, then wait it out.
	task automatic run_op(mdu_op_t kind, word_t a, word_t b);
		logic is_long;
		is_long = !(kind inside {op_none, op_mfhi, op_mflo, op_mthi, op_mtlo});
		@(negedge clk);
		compare_en = !is_long;
		op = kind;
		rs = a;
		rt = b;
		en = 1'b1;
		#1;
		check_value("busy", busy, is_long); // Stall shows in the presenting cycle.
		@(negedge clk);
		{model_hi, model_lo} = mdu_model(kind, a, b, {model_hi, model_lo});
		op = op_none;
		en = 1'b0;
		wait_idle();
		compare_en = 1'b1;
	endtask

	task automatic read_hilo();
		@(negedge clk);
		op = op_mfhi;
		en = 1'b1;
		@(negedge clk);
		op = op_mflo;
		@(negedge clk);
		op = op_none;
		en = 1'b0;
	endtask

	// Compares the read port against the model while the unit is idle.
	always @(posedge clk) begin
		if (compare_en) begin
			check_value("busy", busy, 1'b0);
			case (op)
				op_mfhi: check_value("result (mfhi)", result, model_hi);
				op_mflo: check_value("result (mflo)", result, model_lo);
				default: check_value("result", result, '0);
			endcase
		end
	end

	initial begin
		int i;
		mdu_op_t kind;
		word_t a;
		word_t b;
		seed = 66;
		reset = 1'b1;
		en = 1'b0;
		op = op_none;
		rs = '0;
		rt = '0;
		compare_en = 1'b0;
		model_hi = '0;
		model_lo = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Reset state.
		#1;
		check_value("busy", busy, 1'b0);
		compare_en = 1'b1;
		read_hilo();

		// Moves and a no-op.
		run_op(op_mthi, 32'h1234_5678, 32'h0);
		run_op(op_mtlo, 32'h9abc_def0, 32'h0);
		read_hilo();
		run_op(op_none, 32'hffff_ffff, 32'h5555_aaaa);
		read_hilo();

		for (i = 0; i < 200; i++) begin
			kind = ($random(seed) & 1) ? op_mult : op_multu;
			a = $random(seed);
			b = $random(seed);
			run_op(kind, a, b);
			read_hilo();
		end
		run_op(op_mult, 32'h0, 32'hdead_beef);
		read_hilo();
		run_op(op_multu, 32'hffff_ffff, 32'hffff_ffff);
		read_hilo();
		run_op(op_mult, 32'hffff_ffff, 32'hffff_ffff);
		read_hilo();
		run_op(op_mult, 32'h8000_0000, 32'h8000_0000);
		read_hilo();
		run_op(op_mult, 32'h8000_0000, 32'hffff_ffff);
		read_hilo();
		run_op(op_multu, 32'h8000_0000, 32'h8000_0000);
		read_hilo();

		for (i = 0; i < 200; i++) begin
			kind = ($random(seed) & 1) ? op_div : op_divu;
			a = $random(seed);
			b = $random(seed);
			if (i % 3 == 0) begin
				b = $signed(b) >>> 24; // Small divisors give big quotients.
			end
			if (i % 50 == 7) begin
				b = '0;
			end
			run_op(kind, a, b);
			read_hilo();
		end
		run_op(op_div, 32'h8000_0000, 32'hffff_ffff);
		read_hilo();
		run_op(op_divu, 32'h8000_0000, 32'hffff_ffff);
		read_hilo();
		run_op(op_div, 32'h0000_0007, 32'hffff_fffe);
		read_hilo();
		run_op(op_div, 32'hffff_fff9, 32'h0000_0002);
		read_hilo();
		run_op(op_div, 32'h1357_9bdf, 32'h0);
		read_hilo();
		run_op(op_divu, 32'hfedc_ba98, 32'h0);
		read_hilo();

		// Accumulate chains from a random start.
		run_op(op_mthi, $random(seed), 32'h0);
		run_op(op_mtlo, $random(seed), 32'h0);
		for (i = 0; i < 60; i++) begin
			case ($random(seed) & 3)
				0: kind = op_madd;
				1: kind = op_maddu;
				2: kind = op_msub;
				default: kind = op_msubu;
			endcase
			a = $random(seed);
			b = $random(seed);
			run_op(kind, a, b);
			read_hilo();
		end
		run_op(op_mthi, 32'hffff_ffff, 32'h0);
		run_op(op_mtlo, 32'hffff_ffff, 32'h0);
		run_op(op_maddu, 32'hffff_ffff, 32'hffff_ffff); // Wraps past 64 bits.
		read_hilo();
		run_op(op_mthi, 32'h0, 32'h0);
		run_op(op_mtlo, 32'h0, 32'h0);
		run_op(op_msubu, 32'h1, 32'h1);
		read_hilo();
		run_op(op_msub, 32'h8000_0000, 32'h8000_0000);
		read_hilo();

		// Ops presented during a divide by zero must be dropped.
		@(negedge clk);
		compare_en = 1'b0;
		op = op_div;
		rs = 32'h0bad_f00d;
		rt = 32'h0;
		en = 1'b1;
		#1;
		check_value("busy", busy, 1'b1);
		@(negedge clk);
		{model_hi, model_lo} = mdu_model(op_div, rs, rt, {model_hi, model_lo});
		op = op_mthi;
		rs = 32'hdead_beef;
		#1;
		check_value("busy", busy, 1'b1);
		@(negedge clk);
		op = op_divu;
		rs = 32'h0000_0064;
		rt = 32'h0000_0007;
		#1;
		check_value("busy", busy, 1'b1);
		@(negedge clk);
		op = op_mtlo;
		rs = 32'h5a5a_5a5a;
		#1;
		check_value("busy", busy, 1'b1);
		@(negedge clk);
		op = op_mfhi;
		#1;
		check_value("busy", busy, 1'b1);
		check_value("result", result, '0); // HI is hidden while busy.
		@(negedge clk);
		op = op_none;
		en = 1'b0;
		wait_idle();
		compare_en = 1'b1;
		read_hilo();

		$display("test passed");
		$finish;
	end

endmodule

/* mdu.f */
source/mdu_pkg.sv
source/mdu_multiplier.sv
source/mdu_divider.sv
source/mdu_control.sv
source/mdu.sv
tests/mdu_tb.sv
